// File: design/io_pkg.sv
package io_pkg;

  ////////////////////
  // Bus types
  ////////////////////

  typedef logic [10:0] io_addr_t;
  typedef logic [31:0] io_word_t;

  // One access as the CPU-side master presents it.
  typedef struct packed {
    logic     read;
    logic     write;
    io_addr_t address;
    io_word_t wdata;
    logic [3:0] be;
  } io_req_t;

  // What each peripheral sees. Strobes are one cycle wide.
  typedef struct packed {
    logic     read;
    logic     write;
    logic     reg_sel;
    io_word_t wdata;
    logic [3:0] be;
  } periph_req_t;

  typedef enum logic [2:0] {
    region_uart0,
    region_uart1,
    region_switch,
    region_spi,
    region_none
  } io_region_e;

  ////////////////////
  // Register map
  ////////////////////

  localparam io_addr_t uart0_hi  = 11'h007;
  localparam io_addr_t uart1_lo  = 11'h008;
  localparam io_addr_t uart1_hi  = 11'h00f;
  localparam io_addr_t switch_lo = 11'h010;
  localparam io_addr_t switch_hi = 11'h013;
  localparam io_addr_t spi_lo    = 11'h020;
  localparam io_addr_t spi_hi    = 11'h027;

  // Status word bit positions.
  localparam int uart_stat_tx_busy  = 0;
  localparam int uart_stat_rx_valid = 1;
  localparam int spi_stat_busy      = 0;
  localparam int spi_stat_wp        = 1;

endpackage

// File: design/io_decoder.sv
`timescale 1ns/1ps

module io_decoder (
  input  logic                clk,
  input  logic                rst_n,
  input  io_pkg::io_req_t     req,
  input  logic [15:0]         sw,
  input  io_pkg::io_word_t    uart0_rdata,
  input  io_pkg::io_word_t    uart1_rdata,
  input  io_pkg::io_word_t    spi_rdata,
  output io_pkg::periph_req_t uart0_req,
  output io_pkg::periph_req_t uart1_req,
  output io_pkg::periph_req_t spi_req,
  output io_pkg::io_word_t    data_out,
  output logic                wait_out
);
  import io_pkg::*;

  io_region_e  region;
  logic [1:0]  io_delay;
  logic [15:0] sw_meta;
  logic [15:0] sw_sync;
  logic        rd_go;
  logic        wr_go;
  periph_req_t base_req;

  always_comb begin
    if (req.address <= uart0_hi)
      region = region_uart0;
    else if (req.address >= uart1_lo && req.address <= uart1_hi)
      region = region_uart1;
    else if (req.address >= switch_lo && req.address <= switch_hi)
      region = region_switch;
    else if (req.address >= spi_lo && req.address <= spi_hi)
      region = region_spi;
    else
      region = region_none;
  end

  // The delay register drains toward zero while an access is held, so the
  // first cycle of any access sees wait high and the rest see it low.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_delay <= 2'b11;
    end else if (req.read || req.write) begin
      io_delay <= {io_delay[0], 1'b0};
    end else begin
      io_delay <= 2'b11;
    end
  end

  assign wait_out = io_delay[0];
  assign rd_go    = req.read & ~wait_out;
  assign wr_go    = req.write & ~wait_out;

  assign base_req = '{read: 1'b0, write: 1'b0, reg_sel: req.address[0],
                      wdata: req.wdata, be: req.be};

  always_comb begin
    uart0_req       = base_req;
    uart1_req       = base_req;
    spi_req         = base_req;
    uart0_req.read  = rd_go && (region == region_uart0);
    uart0_req.write = wr_go && (region == region_uart0);
    uart1_req.read  = rd_go && (region == region_uart1);
    uart1_req.write = wr_go && (region == region_uart1);
    spi_req.read    = rd_go && (region == region_spi);
    spi_req.write   = wr_go && (region == region_spi);
  end

  // Switches are asynchronous to the bus clock.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  always_comb begin
    unique case (region)
      region_uart0:  data_out = uart0_rdata;
      region_uart1:  data_out = uart1_rdata;
      region_switch: data_out = {16'h0000, sw_sync};
      region_spi:    data_out = spi_rdata;
      default:       data_out = '0;
    endcase
  end

endmodule

// File: design/uart_port.sv
`timescale 1ns/1ps

module uart_port #(
  parameter int clks_per_bit = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  io_pkg::periph_req_t req,
  input  logic                rx,
  output logic                tx,
  output io_pkg::io_word_t    rdata,
  output logic [1:0]          irq
);
  import io_pkg::*;

  localparam int cnt_w = $clog2(clks_per_bit + 1);
  localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

  logic             tx_busy;
  logic             tx_idle;
  logic [9:0]       tx_shift;
  logic [3:0]       tx_bit_cnt;
  logic [cnt_w-1:0] tx_baud_cnt;
  logic             tx_load;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_active;
  logic [3:0]       rx_bit_cnt;
  logic [cnt_w-1:0] rx_baud_cnt;
  logic             rx_sample;
  logic             rx_done;
  logic             rx_valid;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_data;

  ////////////////////
  // Transmitter
  ////////////////////

  assign tx_load = req.write && !req.reg_sel && req.be[0] && !tx_busy;
  assign tx      = tx_shift[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy     <= 1'b0;
      tx_idle     <= 1'b0;
      tx_shift    <= '1;
      tx_bit_cnt  <= '0;
      tx_baud_cnt <= '0;
    end else if (tx_load) begin
      tx_busy     <= 1'b1;
      tx_idle     <= 1'b0;
      // Stop bit, data LSB first, start bit.
      tx_shift    <= {1'b1, req.wdata[7:0], 1'b0};
      tx_bit_cnt  <= '0;
      tx_baud_cnt <= '0;
    end else if (tx_busy) begin
      if (tx_baud_cnt == bit_last) begin
        tx_baud_cnt <= '0;
        tx_shift    <= {1'b1, tx_shift[9:1]};
        if (tx_bit_cnt == 4'd9) begin
          tx_busy <= 1'b0;
          tx_idle <= 1'b1;
        end else begin
          tx_bit_cnt <= tx_bit_cnt + 4'd1;
        end
      end else begin
        tx_baud_cnt <= tx_baud_cnt + 1'b1;
      end
    end else begin
      tx_idle <= 1'b1;
    end
  end

  ////////////////////
  // Receiver
  ////////////////////

  // Sample 0 is the start bit, 1 to 8 are data and 9 is the stop bit.
  assign rx_sample = rx_active && (rx_baud_cnt == '0);
  assign rx_done   = rx_sample && (rx_bit_cnt == 4'd9) && rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta     <= 1'b1;
      rx_sync     <= 1'b1;
      rx_active   <= 1'b0;
      rx_bit_cnt  <= '0;
      rx_baud_cnt <= '0;
      rx_valid    <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (req.read && !req.reg_sel)
        rx_valid <= 1'b0;
      if (!rx_active) begin
        if (!rx_sync) begin
          rx_active   <= 1'b1;
          rx_bit_cnt  <= '0;
          rx_baud_cnt <= half_last;
        end
      end else if (rx_sample) begin
        rx_baud_cnt <= bit_last;
        rx_bit_cnt  <= rx_bit_cnt + 4'd1;
        // A start bit that is high again at mid-bit was a glitch.
        if ((rx_bit_cnt == 4'd0 && rx_sync) || rx_bit_cnt == 4'd9)
          rx_active <= 1'b0;
        if (rx_done)
          rx_valid <= 1'b1;
      end else begin
        rx_baud_cnt <= rx_baud_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_sample && rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9)
      rx_shift <= {rx_sync, rx_shift[7:1]};
    if (rx_done)
      rx_data <= rx_shift;
  end

  always_comb begin
    rdata = '0;
    if (!req.reg_sel) begin
      rdata[8:0] = {rx_valid, rx_data};
    end else begin
      rdata[uart_stat_tx_busy]  = tx_busy;
      rdata[uart_stat_rx_valid] = rx_valid;
    end
  end

  assign irq = {tx_idle, rx_valid};

endmodule

// File: design/spi_master.sv
`timescale 1ns/1ps

module spi_master #(
  parameter int spi_half_period = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  io_pkg::periph_req_t req,
  input  logic                miso,
  input  logic                wp_n,
  output logic                mosi,
  output logic                sclk,
  output logic [7:0]          selects,
  output io_pkg::io_word_t    rdata
);
  import io_pkg::*;

  localparam int cnt_w = $clog2(spi_half_period + 1);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(spi_half_period - 1);

  logic             busy;
  logic [cnt_w-1:0] half_cnt;
  logic [3:0]       edge_cnt;
  logic             start;
  logic             tick;
  logic             rise;
  logic             fall;
  logic             last;
  logic [7:0]       tx_shift;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_byte;
  logic [1:0]       status;

  assign start = req.write && !req.reg_sel && !busy;
  assign tick  = busy && (half_cnt == half_last);
  assign rise  = tick && !sclk;
  assign fall  = tick && sclk;
  // Sixteen half periods make one byte.
  assign last  = fall && (edge_cnt == 4'd15);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      half_cnt <= '0;
      edge_cnt <= '0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
    end else if (start) begin
      busy     <= 1'b1;
      half_cnt <= '0;
      edge_cnt <= '0;
      mosi     <= req.wdata[7];
    end else if (busy) begin
      if (tick) begin
        half_cnt <= '0;
        sclk     <= ~sclk;
        edge_cnt <= edge_cnt + 4'd1;
        if (last)
          busy <= 1'b0;
        else if (fall)
          mosi <= tx_shift[7];
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // Selects are active low and idle high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects <= 8'hff;
    end else if (req.write && req.reg_sel && req.be[0]) begin
      selects <= req.wdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (start)
      tx_shift <= {req.wdata[6:0], 1'b0};
    else if (fall && !last)
      tx_shift <= {tx_shift[6:0], 1'b0};
    if (rise)
      rx_shift <= {rx_shift[6:0], miso};
    if (last)
      rx_byte <= rx_shift;
  end

  always_comb begin
    status                = '0;
    status[spi_stat_busy] = busy;
    status[spi_stat_wp]   = wp_n;
  end

  always_comb begin
    if (!req.reg_sel)
      rdata = {24'h000000, rx_byte};
    else
      rdata = {22'h000000, status, selects};
  end

endmodule

// File: design/io_controller.sv
`timescale 1ns/1ps

module io_controller #(
  parameter int clks_per_bit    = 16,
  parameter int spi_half_period = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             read,
  input  logic             write,
  input  io_pkg::io_addr_t address,
  input  io_pkg::io_word_t data_in,
  input  logic [3:0]       be,
  output io_pkg::io_word_t data_out,
  output logic             wait_out,
  input  logic             rx0,
  input  logic             rx1,
  output logic             tx0,
  output logic             tx1,
  input  logic             miso,
  output logic             mosi,
  output logic             sclk,
  input  logic             sd_wp_n,
  output logic [7:0]       spi_selects,
  output logic [1:0]       interrupt,
  input  logic [15:0]      sw
);
  import io_pkg::*;

  io_req_t     bus_req;
  periph_req_t uart0_req;
  periph_req_t uart1_req;
  periph_req_t spi_req;
  io_word_t    uart0_rdata;
  io_word_t    uart1_rdata;
  io_word_t    spi_rdata;

  assign bus_req = '{read: read, write: write, address: address, wdata: data_in, be: be};

  io_decoder u_decoder (
    .clk, .rst_n, .req(bus_req), .sw,
    .uart0_rdata, .uart1_rdata, .spi_rdata,
    .uart0_req, .uart1_req, .spi_req,
    .data_out, .wait_out
  );

  // Only port 0 raises interrupts.
  uart_port #(.clks_per_bit(clks_per_bit)) u_uart0 (
    .clk, .rst_n, .req(uart0_req), .rx(rx0), .tx(tx0),
    .rdata(uart0_rdata), .irq(interrupt)
  );

  uart_port #(.clks_per_bit(clks_per_bit)) u_uart1 (
    .clk, .rst_n, .req(uart1_req), .rx(rx1), .tx(tx1),
    .rdata(uart1_rdata), .irq()
  );

  spi_master #(.spi_half_period(spi_half_period)) u_spi (
    .clk, .rst_n, .req(spi_req), .miso, .wp_n(sd_wp_n),
    .mosi, .sclk, .selects(spi_selects), .rdata(spi_rdata)
  );

endmodule

// File: verification/io_controller_chk.sv
`timescale 1ns/1ps

module io_controller_chk (
  input logic                clk,
  input logic                rst_n,
  input logic                read,
  input logic                write,
  input logic                wait_out,
  input io_pkg::periph_req_t uart0_req,
  input io_pkg::periph_req_t uart1_req,
  input io_pkg::periph_req_t spi_req
);

  logic [5:0] strobes;

  assign strobes = {uart0_req.read, uart0_req.write, uart1_req.read,
                    uart1_req.write, spi_req.read, spi_req.write};

  a_wait_first: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(read || write) |-> wait_out)
    else $error("wait_out low in the first cycle of an access");

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(strobes))
    else $error("more than one peripheral strobe in one cycle");

  // A strobe only follows a cycle in which the same access was held in wait.
  a_strobe_after_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (|strobes) |-> $past(wait_out && (read || write)))
    else $error("peripheral strobe without a preceding wait cycle");

  // A held access would repeat its strobe, so the master must have let go.
  a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (|strobes) |=> !(|strobes))
    else $error("peripheral strobe repeated by a held access");

endmodule

bind io_controller io_controller_chk u_chk (
  .clk(clk), .rst_n(rst_n), .read(read), .write(write), .wait_out(wait_out),
  .uart0_req(uart0_req), .uart1_req(uart1_req), .spi_req(spi_req)
);

// File: verification/tb_io_controller.sv
`timescale 1ns/1ps

module tb_io_controller;

  localparam int clks_per_bit    = 16;
  localparam int spi_half_period = 4;
  localparam int n_unmapped      = 16;
  localparam int n_switch        = 6;
  localparam int n_uart          = 3;
  localparam int n_spi           = 5;
  // Each operation is bounded by one UART frame plus bus and polling overhead.
  localparam int n_ops          = n_unmapped + n_switch + 4 * n_uart + n_spi;
  localparam int timeout_cycles = n_ops * (12 * clks_per_bit + 64);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        read;
  logic        write;
  logic [10:0] address;
  logic [31:0] data_in;
  logic [3:0]  be;
  logic [31:0] data_out;
  logic        wait_out;
  logic        rx0;
  logic        rx1;
  logic        tx0;
  logic        tx1;
  logic        miso;
  logic        mosi;
  logic        sclk;
  logic        sd_wp_n;
  logic [7:0]  spi_selects;
  logic [1:0]  interrupt;
  logic [15:0] sw;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;

  // Reference model of the register contents while every peripheral is idle.
  logic [15:0] sw_m;
  logic [7:0]  sel_m;
  logic        wp_m;
  logic [7:0]  spi_rx_m;
  logic [7:0]  uart_rx_m [2];
  logic        uart_valid_m [2];

  io_controller #(
    .clks_per_bit(clks_per_bit),
    .spi_half_period(spi_half_period)
  ) u_dut (
    .clk, .rst_n, .read, .write, .address, .data_in, .be, .data_out, .wait_out,
    .rx0, .rx1, .tx0, .tx1, .miso, .mosi, .sclk, .sd_wp_n, .spi_selects,
    .interrupt, .sw
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_cnt);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] expected_read(input logic [10:0] a);
    logic p;
    p = a[3];
    if (a <= 11'h00f) begin
      if (a[0])
        return {30'h0, uart_valid_m[p], 1'b0};
      return {23'h0, uart_valid_m[p], uart_rx_m[p]};
    end
    if (a >= 11'h010 && a <= 11'h013)
      return {16'h0, sw_m};
    if (a >= 11'h020 && a <= 11'h027)
      return a[0] ? {22'h0, wp_m, 1'b0, sel_m} : {24'h0, spi_rx_m};
    return 32'h0;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////
  // Bus master
  ////////////////////

  task automatic bus_cycle(input logic is_write, input logic [10:0] addr,
                           input logic [31:0] wdata, input logic [3:0] byte_en,
                           output logic [31:0] rdata);
    @(posedge clk);
    read    <= !is_write;
    write   <= is_write;
    address <= addr;
    data_in <= wdata;
    be      <= byte_en;
    @(negedge clk);
    check_eq(32'(wait_out), 32'h1, "wait_out in first cycle of access");
    while (wait_out)
      @(negedge clk);
    rdata = data_out;
    @(posedge clk);
    read  <= 1'b0;
    write <= 1'b0;
  endtask

  task automatic do_write(input logic [10:0] addr, input logic [31:0] wdata,
                          input logic [3:0] byte_en);
    logic [31:0] unused_rdata;
    bus_cycle(1'b1, addr, wdata, byte_en, unused_rdata);
  endtask

  task automatic do_read(input logic [10:0] addr, output logic [31:0] rdata);
    bus_cycle(1'b0, addr, 32'h0, 4'h0, rdata);
  endtask

  ////////////////////
  // Line models
  ////////////////////

  task automatic capture_frame(input logic port, output logic [7:0] data);
    logic line;
    int   i;
    line = 1'b1;
    data = 8'h00;
    while (line) begin
      @(negedge clk);
      line = port ? tx1 : tx0;
    end
    repeat (clks_per_bit / 2) @(negedge clk);
    check_eq(32'(port ? tx1 : tx0), 32'h0, "start bit on tx");
    for (i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data = {(port ? tx1 : tx0), data[7:1]};
    end
    repeat (clks_per_bit) @(negedge clk);
    check_eq(32'(port ? tx1 : tx0), 32'h1, "stop bit on tx");
  endtask

  task automatic send_frame(input logic port, input logic [7:0] data);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      if (port)
        rx1 <= frame[0];
      else
        rx0 <= frame[0];
      frame = frame >> 1;
      repeat (clks_per_bit - 1) @(posedge clk);
    end
  endtask

  // Mode 0 slave. The MSB waits on miso before the first rising SCLK edge.
  task automatic spi_slave(input logic [7:0] out_byte, output logic [7:0] in_byte);
    logic [7:0] shift_out;
    logic       prev_sclk;
    logic       fell;
    int         falls;
    shift_out = out_byte;
    prev_sclk = 1'b0;
    falls     = 0;
    in_byte   = 8'h00;
    @(posedge clk);
    miso <= shift_out[7];
    while (falls < 8) begin
      @(negedge clk);
      fell = prev_sclk && !sclk;
      if (sclk && !prev_sclk)
        in_byte = {in_byte[6:0], mosi};
      prev_sclk = sclk;
      @(posedge clk);
      if (fell) begin
        shift_out = {shift_out[6:0], 1'b0};
        miso <= shift_out[7];
        falls++;
      end
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic unmapped_test();
    logic [31:0] r;
    logic [31:0] got;
    logic [10:0] a;
    r = lcg_next();
    a = r[26:16];
    if (a <= 11'h013 || (a >= 11'h020 && a <= 11'h027))
      a[10] = 1'b1;
    do_write(a, lcg_next(), r[3:0]);
    do_read(a, got);
    check_eq(got, 32'h0, "unmapped read");
  endtask

  task automatic switch_test();
    logic [31:0] r;
    logic [31:0] got;
    logic [10:0] a;
    r = lcg_next();
    a = 11'h010 | {9'h0, r[1:0]};
    @(posedge clk);
    sw <= r[31:16];
    sw_m = r[31:16];
    repeat (3) @(posedge clk);
    do_read(a, got);
    check_eq(got, expected_read(a), "switch word");
    do_write(a, lcg_next(), 4'hf);
    do_read(a ^ 11'h001, got);
    check_eq(got, expected_read(a), "switch word after write");
  endtask

  task automatic uart_tx_test(input logic port);
    logic [10:0] base;
    logic [31:0] r;
    logic [31:0] st;
    logic [7:0]  got;
    base = port ? 11'h008 : 11'h000;
    r = lcg_next();
    fork
      capture_frame(port, got);
      begin
        do_write(base, r, 4'b0001);
        do_read(base | 11'h001, st);
        check_eq(32'(st[0]), 32'h1, "tx_busy during frame");
        @(negedge clk);
        if (!port)
          check_eq(32'(interrupt[1]), 32'h0, "tx idle interrupt during frame");
      end
    join
    check_eq(32'(got), 32'(r[7:0]), "byte on tx line");
    st = 32'h1;
    while (st[0])
      do_read(base | 11'h001, st);
    check_eq(st, expected_read(base | 11'h001), "uart status after frame");
    @(negedge clk);
    if (!port)
      check_eq(32'(interrupt[1]), 32'h1, "tx idle interrupt after frame");
  endtask

  task automatic uart_rx_test(input logic port);
    logic [10:0] base;
    logic [31:0] r;
    logic [31:0] got;
    base = port ? 11'h008 : 11'h000;
    r = lcg_next();
    send_frame(port, r[23:16]);
    uart_rx_m[port]    = r[23:16];
    uart_valid_m[port] = 1'b1;
    @(negedge clk);
    if (!port)
      check_eq(32'(interrupt[0]), 32'h1, "rx interrupt with byte waiting");
    do_read(base | {8'h0, r[2:1], 1'b0}, got);
    check_eq(got, expected_read(base), "received byte");
    uart_valid_m[port] = 1'b0;
    @(negedge clk);
    if (!port)
      check_eq(32'(interrupt[0]), 32'h0, "rx interrupt after data read");
    do_read(base | 11'h001, got);
    check_eq(got, expected_read(base | 11'h001), "uart status after data read");
  endtask

  task automatic spi_test();
    logic [31:0] r;
    logic [31:0] got;
    logic [7:0]  cap;
    r = lcg_next();
    fork
      spi_slave(r[15:8], cap);
      begin
        do_write(11'h020, r, 4'b0001);
        do_read(11'h021, got);
        check_eq(32'(got[8]), 32'h1, "spi busy during transfer");
        while (got[8])
          do_read(11'h021, got);
      end
    join
    check_eq(32'(cap), 32'(r[7:0]), "byte on mosi");
    spi_rx_m = r[15:8];
    do_read(11'h020, got);
    check_eq(got, expected_read(11'h020), "spi received byte");
    r = lcg_next();
    @(posedge clk);
    sd_wp_n <= r[8];
    wp_m = r[8];
    do_write(11'h021, r, 4'b0001);
    sel_m = r[7:0];
    do_read(11'h021, got);
    check_eq(got, expected_read(11'h021), "spi selects and status");
    @(negedge clk);
    check_eq(32'(spi_selects), 32'(sel_m), "spi_selects pins");
  endtask

  initial begin
    int i;
    lcg_state       = 32'h523a;
    rst_n           = 1'b0;
    read            = 1'b0;
    write           = 1'b0;
    address         = 11'h000;
    data_in         = 32'h0;
    be              = 4'h0;
    rx0             = 1'b1;
    rx1             = 1'b1;
    miso            = 1'b0;
    sd_wp_n         = 1'b1;
    sw              = 16'h0000;
    sw_m            = 16'h0000;
    sel_m           = 8'hff;
    wp_m            = 1'b1;
    spi_rx_m        = 8'h00;
    uart_rx_m[0]    = 8'h00;
    uart_rx_m[1]    = 8'h00;
    uart_valid_m[0] = 1'b0;
    uart_valid_m[1] = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_eq(32'(interrupt), 32'h2, "interrupt after reset");
    check_eq(32'({tx0, tx1, sclk}), 32'h6, "tx and sclk idle after reset");
    check_eq(32'(spi_selects), 32'hff, "spi_selects after reset");
    for (i = 0; i < n_unmapped; i++)
      unmapped_test();
    for (i = 0; i < n_switch; i++)
      switch_test();
    for (i = 0; i < n_uart; i++) begin
      uart_tx_test(1'b0);
      uart_tx_test(1'b1);
    end
    for (i = 0; i < n_uart; i++) begin
      uart_rx_test(1'b0);
      uart_rx_test(1'b1);
    end
    for (i = 0; i < n_spi; i++)
      spi_test();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: src.f
design/io_pkg.sv
design/io_decoder.sv
design/uart_port.sv
design/spi_master.sv
design/io_controller.sv
verification/io_controller_chk.sv
verification/tb_io_controller.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_io_controller
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "RESULT: PASS"; \
	else echo "RESULT: FAIL"; exit 1; fi

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
